/* all.f */
source/md_audio_pkg.sv
source/fm_dac_decode.sv
source/psg_level_mixer.sv
source/audio_combine.sv
source/md_audio.sv
sim/md_audio_checker.sv
sim/md_audio_tb.sv

/* sim/md_audio_checker.sv */
module md_audio_checker
	(
	input logic MCLK2,
	input logic rst_i,
	input logic out_tick_i,
	input logic sample_valid_o,
	input logic signed [md_audio_pkg::out_sample_w-1:0] left_o,
	input logic signed [md_audio_pkg::out_sample_w-1:0] right_o
	);

	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions, read by the testbench
	int assert_errors = 0;

	// every tick is answered on the next edge
	tick_gives_valid: assert property (@(posedge MCLK2) disable iff (rst_i)
		out_tick_i |=> sample_valid_o)
	else
	begin
		$error("sample_valid_o missing one cycle after out_tick_i");
		assert_errors++;
	end

	// and valid never rises without a tick before it
	valid_needs_tick: assert property (@(posedge MCLK2) disable iff (rst_i)
		$rose(sample_valid_o) |-> $past(out_tick_i))
	else
	begin
		$error("sample_valid_o rose without out_tick_i in the cycle before");
		assert_errors++;
	end

	valid_single_cycle: assert property (@(posedge MCLK2) disable iff (rst_i)
		sample_valid_o |=> !sample_valid_o)
	else
	begin
		$error("sample_valid_o high for two cycles in a row");
		assert_errors++;
	end

	// outputs only move on the edge that raises valid
	outputs_hold: assert property (@(posedge MCLK2) disable iff (rst_i)
		!sample_valid_o |-> ($stable(left_o) && $stable(right_o)))
	else
	begin
		$error("left_o or right_o changed while sample_valid_o was low");
		assert_errors++;
	end

	valid_low_after_reset: assert property (@(posedge MCLK2)
		rst_i |=> !sample_valid_o)
	else
	begin
		$error("sample_valid_o high in the cycle after reset");
		assert_errors++;
	end

endmodule

bind md_audio md_audio_checker checker_i
	(
	.MCLK2(MCLK2),
	.rst_i(rst_i),
	.out_tick_i(out_tick_i),
	.sample_valid_o(sample_valid_o),
	.left_o(left_o),
	.right_o(right_o)
	);

/* sim/md_audio_input.txt */
# op mode fm_left fm_right psg_level psg_att exp_left exp_right, all hex
# op 1 strobes fm and psg before the tick, op 0 only ticks
0 0 000 000 0 0000 00000 00000
0 1 3FF 1FF F 0000 00000 00000
1 0 100 1FF F FFFF 00000 03FC0
1 0 000 100 F FFFF 3C000 00000
1 0 2FF 3FF F FFFF 3FFC0 03FC0
1 0 1FF 000 0 0000 03FC0 3C000
1 1 1FF 200 F FFFF 17F40 28000
1 1 3FF 000 0 0000 3FF40 00000
1 1 155 2AA F FFFF 0FFC0 2FF80
1 1 001 3FE F FFFF 000C0 3FE80
1 0 100 100 F 0000 07FFC 07FFC
1 0 100 100 1 0000 01FFF 01FFF
1 0 100 100 2 0010 0196A 0196A
1 0 100 100 F 3210 05DA2 05DA2
1 0 100 100 5 FEDC 0034B 0034B
1 0 100 100 A 9876 00A69 00A69
1 0 100 100 E 5A4B 01A0E 01A0E
1 0 100 100 7 0123 03DA3 03DA3
1 0 100 100 F EEEE 00518 00518
1 0 100 100 F DCBA 0095E 0095E
1 0 100 100 F 8888 01448 01448
1 0 100 100 0 0000 00000 00000
1 0 100 100 8 F000 00000 00000
1 0 1FF 000 F 0000 0BFBC 03FFC
1 1 200 1FF 3 0011 2B2D4 1B214
1 1 3F0 010 4 0200 00830 02030
1 1 1FF 200 F 0000 1FF3C 2FFFC
1 0 0C0 140 1 0005 3FA1E 01A1E
0 0 0C0 140 1 0005 3FA1E 01A1E
0 1 3FF 000 F 0000 3FA1E 01A1E
0 0 100 100 0 FFFF 3FA1E 01A1E

/* sim/md_audio_tb.sv */
module md_audio_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_half_ns = 20;
	localparam int clk_period_ns = 40;

	logic MCLK2;
	logic rst_i;
	logic fm_strobe_i;
	logic fm_ladder_i;
	logic [md_audio_pkg::fm_word_w-1:0] fm_left_i;
	logic [md_audio_pkg::fm_word_w-1:0] fm_right_i;
	logic psg_strobe_i;
	logic [md_audio_pkg::psg_channels-1:0] psg_level_i;
	logic [md_audio_pkg::psg_channels*md_audio_pkg::psg_att_w-1:0] psg_att_i;
	logic out_tick_i;
	logic signed [md_audio_pkg::out_sample_w-1:0] left_o;
	logic signed [md_audio_pkg::out_sample_w-1:0] right_o;
	logic sample_valid_o;

	// one entry per vector line
	logic op_q [$];
	logic mode_q [$];
	logic [md_audio_pkg::fm_word_w-1:0] fm_left_q [$];
	logic [md_audio_pkg::fm_word_w-1:0] fm_right_q [$];
	logic [md_audio_pkg::psg_channels-1:0] level_q [$];
	logic [md_audio_pkg::psg_channels*md_audio_pkg::psg_att_w-1:0] att_q [$];
	logic [md_audio_pkg::out_sample_w-1:0] exp_left_q [$];
	logic [md_audio_pkg::out_sample_w-1:0] exp_right_q [$];

	int value_errors = 0;
	int valid_errors = 0;
	int other_errors = 0;
	bit load_done = 1'b0;

	md_audio dut_i
		(
		.MCLK2(MCLK2),
		.rst_i(rst_i),
		.fm_strobe_i(fm_strobe_i),
		.fm_ladder_i(fm_ladder_i),
		.fm_left_i(fm_left_i),
		.fm_right_i(fm_right_i),
		.psg_strobe_i(psg_strobe_i),
		.psg_level_i(psg_level_i),
		.psg_att_i(psg_att_i),
		.out_tick_i(out_tick_i),
		.left_o(left_o),
		.right_o(right_o),
		.sample_valid_o(sample_valid_o)
		);

	initial
	begin
		MCLK2 = 1'b0;
		forever #clk_half_ns MCLK2 = ~MCLK2;
	end

	task automatic load_vectors;
		int fd;
		int n;
		int code;
		string line;
		logic op;
		logic mode;
		logic [md_audio_pkg::fm_word_w-1:0] fl;
		logic [md_audio_pkg::fm_word_w-1:0] fr;
		logic [md_audio_pkg::psg_channels-1:0] lvl;
		logic [md_audio_pkg::psg_channels*md_audio_pkg::psg_att_w-1:0] att;
		logic [md_audio_pkg::out_sample_w-1:0] el;
		logic [md_audio_pkg::out_sample_w-1:0] er;

		fd = $fopen("sim/md_audio_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the vector file sim/md_audio_input.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() == 0)
				continue;
			// header lines
			if (line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h", op, mode, fl, fr, lvl, att, el, er);
			if (n == 8)
			begin
				op_q.push_back(op);
				mode_q.push_back(mode);
				fm_left_q.push_back(fl);
				fm_right_q.push_back(fr);
				level_q.push_back(lvl);
				att_q.push_back(att);
				exp_left_q.push_back(el);
				exp_right_q.push_back(er);
			end
			else if (n > 0)
			begin
				$display("a line of the vector file has %0d fields instead of 8", n);
				other_errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_output(input int idx);
		assert (sample_valid_o === 1'b1)
		else
		begin
			$display("no valid pulse in the cycle after the output tick of vector %0d", idx);
			valid_errors++;
		end
		assert (left_o === exp_left_q[idx])
		else
		begin
			$display("CHECK FAILED vector %0d left_o expected %05h actual %05h",
				idx, exp_left_q[idx], left_o);
			value_errors++;
		end
		assert (right_o === exp_right_q[idx])
		else
		begin
			$display("CHECK FAILED vector %0d right_o expected %05h actual %05h",
				idx, exp_right_q[idx], right_o);
			value_errors++;
		end
	endtask

	// starts and ends on a falling edge
	task automatic apply_vector(input int idx);
		fm_ladder_i = mode_q[idx];
		fm_left_i = fm_left_q[idx];
		fm_right_i = fm_right_q[idx];
		psg_level_i = level_q[idx];
		psg_att_i = att_q[idx];
		// op 0 changes the inputs without a strobe
		if (op_q[idx])
		begin
			fm_strobe_i = 1'b1;
			psg_strobe_i = 1'b1;
		end
		@(negedge MCLK2);
		fm_strobe_i = 1'b0;
		psg_strobe_i = 1'b0;
		@(negedge MCLK2);
		out_tick_i = 1'b1;
		@(negedge MCLK2);
		out_tick_i = 1'b0;
		check_output(idx);
	endtask

	initial
	begin
		rst_i = 1'b1;
		fm_strobe_i = 1'b0;
		fm_ladder_i = 1'b0;
		fm_left_i = '0;
		fm_right_i = '0;
		psg_strobe_i = 1'b0;
		psg_level_i = '0;
		psg_att_i = '0;
		out_tick_i = 1'b0;

		load_vectors();
		load_done = 1'b1;

		repeat (3) @(posedge MCLK2);
		@(negedge MCLK2);
		rst_i = 1'b0;
		@(negedge MCLK2);

		for (int i = 0; i < op_q.size(); i++)
		begin
			apply_vector(i);
		end

		// let the last concurrent assertions complete
		repeat (2) @(negedge MCLK2);

		$display("errors: %0d value, %0d valid pulse, %0d assertion, %0d other",
			value_errors, valid_errors, dut_i.checker_i.assert_errors, other_errors);
		if (value_errors + valid_errors + dut_i.checker_i.assert_errors
			+ other_errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	// limit is 5 cycles per vector plus 20 for reset
	initial
	begin
		int limit_cycles;

		wait (load_done);
		limit_cycles = op_q.size() * 5 + 20;
		#(limit_cycles * clk_period_ns);
		$display("watchdog expired after %0d cycles before all vectors were applied",
			limit_cycles);
		$display("errors: %0d value, %0d valid pulse, %0d assertion, %0d other",
			value_errors, valid_errors, dut_i.checker_i.assert_errors, other_errors);
		$display("Test failed");
		$finish;
	end

endmodule

/* source/audio_combine.sv */
module audio_combine
	(
	input logic MCLK2,
	input logic rst_i,

	input logic out_tick_i,
	input logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_left_i,
	input logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_right_i,
	input logic [md_audio_pkg::psg_sample_w-1:0] psg_sum_i,

	output logic signed [md_audio_pkg::out_sample_w-1:0] left_o,
	output logic signed [md_audio_pkg::out_sample_w-1:0] right_o,
	output logic sample_valid_o
	);

	// psg is unsigned, zero extend before the signed add
	logic signed [md_audio_pkg::out_sample_w-1:0] psg_ext;

	logic signed [md_audio_pkg::out_sample_w-1:0] left_sum;
	logic signed [md_audio_pkg::out_sample_w-1:0] right_sum;

	logic signed [md_audio_pkg::out_sample_w-1:0] left_q;
	logic signed [md_audio_pkg::out_sample_w-1:0] right_q;
	logic valid_q;

	assign psg_ext = signed'({{(md_audio_pkg::out_sample_w-md_audio_pkg::psg_sample_w){1'b0}},
		psg_sum_i});

	assign left_sum = fm_left_i + psg_ext;
	assign right_sum = fm_right_i + psg_ext;

	always_ff @(posedge MCLK2)
	begin
		if (rst_i)
		begin
			left_q <= '0;
			right_q <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			// one cycle valid per tick
			valid_q <= out_tick_i;
			if (out_tick_i)
			begin
				left_q <= left_sum;
				right_q <= right_sum;
			end
		end
	end

	assign left_o = left_q;
	assign right_o = right_q;
	assign sample_valid_o = valid_q;

endmodule

/* source/fm_dac_decode.sv */
module fm_dac_decode
	(
	input logic MCLK2,
	input logic rst_i,

	input logic fm_strobe_i,
	input logic fm_ladder_i,
	input logic [md_audio_pkg::fm_word_w-1:0] fm_left_i,
	input logic [md_audio_pkg::fm_word_w-1:0] fm_right_i,

	output logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_left_o,
	output logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_right_o
	);

	// both decodes of one word, selected by mode
	function automatic logic signed [md_audio_pkg::fm_scaled_w-1:0] decode_word
		(
		input md_audio_pkg::fm_sample_u word,
		input logic ladder
		);
		logic signed [8:0] centered;
		logic signed [md_audio_pkg::fm_scaled_w-1:0] lin_val;
		logic signed [md_audio_pkg::fm_scaled_w-1:0] hi_part;
		logic signed [md_audio_pkg::fm_scaled_w-1:0] lo_part;
		logic signed [md_audio_pkg::fm_scaled_w-1:0] lad_val;

		// ym3438: unsigned around 256, times 64
		centered = word.linear.level - 9'd256;
		lin_val = {{3{centered[8]}}, centered, 6'h0};

		// ym2612: times 128 plus times 64
		hi_part = {word.ladder[9], word.ladder, 7'h0};
		lo_part = {{2{word.ladder[9]}}, word.ladder, 6'h0};
		lad_val = hi_part + lo_part;

		if (ladder)
		begin
			decode_word = lad_val;
		end
		else
		begin
			decode_word = lin_val;
		end
	endfunction

	md_audio_pkg::fm_sample_u left_word;
	md_audio_pkg::fm_sample_u right_word;

	logic signed [md_audio_pkg::fm_scaled_w-1:0] left_dec;
	logic signed [md_audio_pkg::fm_scaled_w-1:0] right_dec;

	logic signed [md_audio_pkg::fm_scaled_w-1:0] left_q;
	logic signed [md_audio_pkg::fm_scaled_w-1:0] right_q;

	assign left_word = fm_left_i;
	assign right_word = fm_right_i;

	// mode is used at the strobe only
	always_comb
	begin
		left_dec = decode_word(left_word, fm_ladder_i);
		right_dec = decode_word(right_word, fm_ladder_i);
	end

	always_ff @(posedge MCLK2)
	begin
		if (rst_i)
		begin
			left_q <= '0;
			right_q <= '0;
		end
		else if (fm_strobe_i)
		begin
			left_q <= left_dec;
			right_q <= right_dec;
		end
	end

	assign fm_left_o = left_q;
	assign fm_right_o = right_q;

endmodule

/* source/md_audio.sv */
module md_audio
	(
	input logic MCLK2,
	input logic rst_i,

	// fm chip outputs
	input logic fm_strobe_i,
	input logic fm_ladder_i,
	input logic [md_audio_pkg::fm_word_w-1:0] fm_left_i,
	input logic [md_audio_pkg::fm_word_w-1:0] fm_right_i,

	// psg channel state
	input logic psg_strobe_i,
	input logic [md_audio_pkg::psg_channels-1:0] psg_level_i,
	input logic [md_audio_pkg::psg_channels*md_audio_pkg::psg_att_w-1:0] psg_att_i,

	input logic out_tick_i,

	output logic signed [md_audio_pkg::out_sample_w-1:0] left_o,
	output logic signed [md_audio_pkg::out_sample_w-1:0] right_o,
	output logic sample_valid_o
	);

	logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_left_s;
	logic signed [md_audio_pkg::fm_scaled_w-1:0] fm_right_s;
	logic [md_audio_pkg::psg_sample_w-1:0] psg_sum;

	fm_dac_decode fm_dec
		(
		.MCLK2(MCLK2),
		.rst_i(rst_i),
		.fm_strobe_i(fm_strobe_i),
		.fm_ladder_i(fm_ladder_i),
		.fm_left_i(fm_left_i),
		.fm_right_i(fm_right_i),
		.fm_left_o(fm_left_s),
		.fm_right_o(fm_right_s)
		);

	psg_level_mixer psg_mix
		(
		.MCLK2(MCLK2),
		.rst_i(rst_i),
		.psg_strobe_i(psg_strobe_i),
		.psg_level_i(psg_level_i),
		.psg_att_i(psg_att_i),
		.psg_sum_o(psg_sum)
		);

	// mono psg onto both fm sides
	audio_combine mix
		(
		.MCLK2(MCLK2),
		.rst_i(rst_i),
		.out_tick_i(out_tick_i),
		.fm_left_i(fm_left_s),
		.fm_right_i(fm_right_s),
		.psg_sum_i(psg_sum),
		.left_o(left_o),
		.right_o(right_o),
		.sample_valid_o(sample_valid_o)
		);

endmodule

/* source/md_audio_pkg.sv */
package md_audio_pkg;

	// raw FM word from the chip outputs
	localparam int fm_word_w = 10;

	// decoded FM value and stereo output, both signed
	localparam int fm_scaled_w = 18;
	localparam int out_sample_w = 18;

	// PSG side
	localparam int psg_sample_w = 16;
	localparam int psg_att_w = 4;
	localparam int psg_channels = 4;
	localparam int psg_vol_w = 13;

	// one FM word, ym3438 linear or ym2612 ladder
	typedef union packed {
		struct packed {
			logic pad;
			logic [8:0] level;
		} linear;
		logic signed [fm_word_w-1:0] ladder;
	} fm_sample_u;

	// 2 dB per step, full scale 8191, step 15 mutes
	localparam logic [psg_vol_w-1:0] psg_volume_table [0:15] = '{
		13'd8191,
		13'd6506,
		13'd5168,
		13'd4105,
		13'd3261,
		13'd2590,
		13'd2057,
		13'd1634,
		13'd1298,
		13'd1031,
		13'd819,
		13'd651,
		13'd517,
		13'd411,
		13'd326,
		13'd0
	};

endpackage

/* source/psg_level_mixer.sv */
module psg_level_mixer
	(
	input logic MCLK2,
	input logic rst_i,

	input logic psg_strobe_i,
	input logic [md_audio_pkg::psg_channels-1:0] psg_level_i,
	input logic [md_audio_pkg::psg_channels*md_audio_pkg::psg_att_w-1:0] psg_att_i,

	output logic [md_audio_pkg::psg_sample_w-1:0] psg_sum_o
	);

	// per channel attenuation, channel 0 in the low bits
	logic [md_audio_pkg::psg_att_w-1:0] att [md_audio_pkg::psg_channels];

	// table level and gated level of each channel
	logic [md_audio_pkg::psg_vol_w-1:0] vol [md_audio_pkg::psg_channels];
	logic [md_audio_pkg::psg_vol_w-1:0] gated [md_audio_pkg::psg_channels];

	logic [md_audio_pkg::psg_sample_w-1:0] sum_d;
	logic [md_audio_pkg::psg_sample_w-1:0] sum_q;

	// split the packed attenuation word
	always_comb
	begin
		for (int ch = 0; ch < md_audio_pkg::psg_channels; ch++)
		begin
			att[ch] = psg_att_i[ch*md_audio_pkg::psg_att_w +: md_audio_pkg::psg_att_w];
		end
	end

	// volume lookup
	always_comb
	begin
		for (int ch = 0; ch < md_audio_pkg::psg_channels; ch++)
		begin
			vol[ch] = md_audio_pkg::psg_volume_table[att[ch]];
		end
	end

	// square output low means silent
	always_comb
	begin
		for (int ch = 0; ch < md_audio_pkg::psg_channels; ch++)
		begin
			if (psg_level_i[ch])
			begin
				gated[ch] = vol[ch];
			end
			else
			begin
				gated[ch] = '0;
			end
		end
	end

	// 4 x 8191 = 32764, no overflow in 16 bits
	always_comb
	begin
		sum_d = '0;
		for (int ch = 0; ch < md_audio_pkg::psg_channels; ch++)
		begin
			sum_d = sum_d + {{(md_audio_pkg::psg_sample_w-md_audio_pkg::psg_vol_w){1'b0}},
				gated[ch]};
		end
	end

	always_ff @(posedge MCLK2)
	begin
		if (rst_i)
		begin
			sum_q <= '0;
		end
		else if (psg_strobe_i)
		begin
			sum_q <= sum_d;
		end
	end

	assign psg_sum_o = sum_q;

endmodule
